// File: rv_decode.f
+incdir+common
common/rv_decode_pkg.sv
decoder/op_classifier.sv
decoder/imm_generator.sv
hdl/decode_handshake.sv
hdl/decode_stage.sv
tests/decode_stage_asserts.sv
tests/decode_stage_tb.sv

// File: tests/decode_stage_tb.sv
// Decode stage testbench
`default_nettype none

`include "rv_decode_defines.svh"

module decode_stage_tb import rv_decode_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TXN_COUNT = 80;                          // Upper bound on transactions
    localparam int RUN_LIMIT = TXN_COUNT * 12 * 8 + 1000;  // ns, with reset margin

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      req;
    logic [`RV_ILEN-1:0]       instr;
    logic                      ack;
    instr_e                    op;
    opcode_e                   opcode;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_SHAMT_W-1:0]    shamt;
    access_size_e              access_size;
    mem_access_e               mem_access;
    logic                      illegal;

    int mismatch_count = 0;
    int protocol_count = 0;

    always #4 clk = ~clk;

    decode_stage dut_i (
        .clk(clk), .reset(reset), .req(req), .instr(instr), .ack(ack),
        .op(op), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .shamt(shamt), .access_size(access_size), .mem_access(mem_access),
        .illegal(illegal)
    );

    bind decode_stage decode_stage_asserts asserts_i (
        .clk(clk), .reset(reset), .req(req), .ack(ack), .op(op),
        .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .shamt(shamt),
        .mem_access(mem_access), .access_size(access_size), .illegal(illegal)
    );

    task automatic check_op(input instr_e got, input instr_e exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s op %s expected %s", $time, what,
                     got.name(), exp.name());
            mismatch_count++;
        end
    endtask

    task automatic check_opcode(input opcode_e got, input opcode_e exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_word(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_reg(input logic [`RV_REG_ADDR_W-1:0] got,
                             input logic [`RV_REG_ADDR_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got x%0d expected x%0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_mem(input mem_access_e got_m, input mem_access_e exp_m,
                             input access_size_e got_s, input access_size_e exp_s,
                             input string what);
        if (got_m !== exp_m || got_s !== exp_s) begin
            $display("MISMATCH at %0t: %s memory %s/%s expected %s/%s", $time, what,
                     got_m.name(), got_s.name(), exp_m.name(), exp_s.name());
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // One four-phase transaction with timing checks
    task automatic send(input logic [`RV_ILEN-1:0] word);
        int edges;
        int hold;
        hold = $urandom_range(0, 3);
        @(posedge clk);
        req   <= 1'b1;
        instr <= word;
        edges = 0;
        while (!ack && edges < 8) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!ack) begin
            $display("Protocol error at %0t: ack never rose for instruction %h", $time, word);
            protocol_count++;
        end else if (edges != 2) begin
            $display("Protocol error at %0t: ack rose %0d cycles after req, not 2", $time, edges);
            protocol_count++;
        end
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            if (!ack) begin
                $display("Protocol error at %0t: ack dropped while req was held", $time);
                protocol_count++;
            end
        end
        @(posedge clk);
        req   <= 1'b0;
        instr <= $urandom(); // Results must not follow instr any more
        @(negedge clk);
        if (!ack) begin
            $display("Protocol error at %0t: ack fell before req was seen low", $time);
            protocol_count++;
        end
        @(posedge clk);
        @(negedge clk);
        if (ack) begin
            $display("Protocol error at %0t: ack stayed high after req dropped", $time);
            protocol_count++;
        end
    endtask

    task automatic expect_result(input string what, input instr_e e_op, input opcode_e e_opc,
                                 input logic [4:0] e_rd, input logic [4:0] e_rs1,
                                 input logic [4:0] e_rs2, input logic [63:0] e_imm,
                                 input logic [5:0] e_shamt, input mem_access_e e_mem,
                                 input access_size_e e_size);
        check_op(op, e_op, what);
        check_opcode(opcode, e_opc, {what, " opcode"});
        check_reg(rd, e_rd, {what, " rd"});
        check_reg(rs1, e_rs1, {what, " rs1"});
        check_reg(rs2, e_rs2, {what, " rs2"});
        check_word(imm, e_imm, {what, " imm"});
        check_word(64'(shamt), 64'(e_shamt), {what, " shamt"});
        check_mem(mem_access, e_mem, access_size, e_size, what);
        check_flag(illegal, e_op == ILLEGAL, {what, " illegal"});
    endtask

    task automatic run_r(input logic [6:0] f7, input logic [2:0] f3, input opcode_e opc,
                         input instr_e exp);
        logic [4:0] rd_v, rs1_v, rs2_v;
        rd_v  = $urandom();
        rs1_v = $urandom();
        rs2_v = $urandom();
        send({f7, rs2_v, rs1_v, f3, rd_v, opc});
        expect_result(exp.name(), exp, opc, rd_v, rs1_v, rs2_v, '0, '0,
                      MEM_NONE, SIZE_BYTE);
    endtask

    // Plain I format, loads and JALR included
    task automatic run_i(input logic [2:0] f3, input opcode_e opc, input instr_e exp,
                         input mem_access_e e_mem, input access_size_e e_size);
        logic [11:0] imm_v;
        logic [4:0]  rd_v, rs1_v;
        logic [5:0]  sh_v;
        imm_v = $urandom();
        rd_v  = $urandom();
        rs1_v = $urandom();
        sh_v  = (opc == OPC_OP_IMM) ? imm_v[5:0] :
                (opc == OPC_OP_IMM_32) ? {1'b0, imm_v[4:0]} : 6'd0;
        send({imm_v, rs1_v, f3, rd_v, opc});
        expect_result(exp.name(), exp, opc, rd_v, rs1_v, '0, {{52{imm_v[11]}}, imm_v},
                      sh_v, e_mem, e_size);
    endtask

    task automatic run_shift(input logic [6:0] f7, input logic [2:0] f3, input opcode_e opc,
                             input instr_e exp);
        logic [5:0]  sh_v;
        logic [4:0]  rd_v, rs1_v;
        logic [31:0] word;
        sh_v  = $urandom();
        rd_v  = $urandom();
        rs1_v = $urandom();
        if (opc == OPC_OP_IMM_32) begin
            sh_v[5] = 1'b0;
            word = {f7, sh_v[4:0], rs1_v, f3, rd_v, opc};
        end else begin
            word = {f7[6:1], sh_v, rs1_v, f3, rd_v, opc};
        end
        send(word);
        expect_result(exp.name(), exp, opc, rd_v, rs1_v, '0,
                      {{52{word[31]}}, word[31:20]}, sh_v, MEM_NONE, SIZE_BYTE);
    endtask

    task automatic run_s(input logic [2:0] f3, input instr_e exp, input access_size_e e_size);
        logic [11:0] imm_v;
        logic [4:0]  rs1_v, rs2_v;
        imm_v = $urandom();
        rs1_v = $urandom();
        rs2_v = $urandom();
        send({imm_v[11:5], rs2_v, rs1_v, f3, imm_v[4:0], OPC_STORE});
        expect_result(exp.name(), exp, OPC_STORE, '0, rs1_v, rs2_v,
                      {{52{imm_v[11]}}, imm_v}, '0, MEM_WRITE, e_size);
    endtask

    task automatic run_b(input logic [2:0] f3, input instr_e exp);
        logic [12:0] imm_v;
        logic [4:0]  rs1_v, rs2_v;
        imm_v = {$urandom(), 1'b0}; // Branch offsets are even
        rs1_v = $urandom();
        rs2_v = $urandom();
        send({imm_v[12], imm_v[10:5], rs2_v, rs1_v, f3, imm_v[4:1], imm_v[11], OPC_BRANCH});
        expect_result(exp.name(), exp, OPC_BRANCH, '0, rs1_v, rs2_v,
                      {{51{imm_v[12]}}, imm_v}, '0, MEM_NONE, SIZE_BYTE);
    endtask

    task automatic run_u(input opcode_e opc, input instr_e exp);
        logic [19:0] imm_v;
        logic [4:0]  rd_v;
        imm_v = $urandom();
        rd_v  = $urandom();
        send({imm_v, rd_v, opc});
        expect_result(exp.name(), exp, opc, rd_v, '0, '0,
                      {{32{imm_v[19]}}, imm_v, 12'h000}, '0, MEM_NONE, SIZE_BYTE);
    endtask

    task automatic run_j();
        logic [20:0] imm_v;
        logic [4:0]  rd_v;
        imm_v = {$urandom(), 1'b0};
        rd_v  = $urandom();
        send({imm_v[20], imm_v[10:1], imm_v[11], imm_v[19:12], rd_v, OPC_JAL});
        expect_result("JAL", JAL, OPC_JAL, rd_v, '0, '0, {{43{imm_v[20]}}, imm_v}, '0,
                      MEM_NONE, SIZE_BYTE);
    endtask

    task automatic run_illegal(input logic [31:0] word, input string what);
        send(word);
        check_op(op, ILLEGAL, what);
        check_flag(illegal, 1'b1, {what, " illegal"});
        check_mem(mem_access, MEM_NONE, access_size, SIZE_BYTE, what);
    endtask

    task automatic test_reset();
        check_flag(ack, 1'b0, "reset ack");
        check_flag(illegal, 1'b1, "reset illegal");
        check_op(op, ILLEGAL, "reset");
    endtask

    task automatic test_reg_ops();
        run_r(7'h00, 3'd0, OPC_OP, ADD);
        run_r(7'h20, 3'd0, OPC_OP, SUB);
        run_r(7'h00, 3'd1, OPC_OP, SLL);
        run_r(7'h00, 3'd2, OPC_OP, SLT);
        run_r(7'h00, 3'd3, OPC_OP, SLTU);
        run_r(7'h00, 3'd4, OPC_OP, XOR);
        run_r(7'h00, 3'd5, OPC_OP, SRL);
        run_r(7'h20, 3'd5, OPC_OP, SRA);
        run_r(7'h00, 3'd6, OPC_OP, OR);
        run_r(7'h00, 3'd7, OPC_OP, AND);
        run_r(7'h01, 3'd0, OPC_OP, MUL);
        run_r(7'h01, 3'd1, OPC_OP, MULH);
        run_r(7'h01, 3'd2, OPC_OP, MULHSU);
        run_r(7'h01, 3'd3, OPC_OP, MULHU);
        run_r(7'h01, 3'd4, OPC_OP, DIV);
        run_r(7'h01, 3'd5, OPC_OP, DIVU);
        run_r(7'h01, 3'd6, OPC_OP, REM);
        run_r(7'h01, 3'd7, OPC_OP, REMU);
        run_r(7'h00, 3'd0, OPC_OP_32, ADDW);
        run_r(7'h20, 3'd0, OPC_OP_32, SUBW);
        run_r(7'h00, 3'd1, OPC_OP_32, SLLW);
        run_r(7'h00, 3'd5, OPC_OP_32, SRLW);
        run_r(7'h20, 3'd5, OPC_OP_32, SRAW);
        run_r(7'h01, 3'd0, OPC_OP_32, MULW);
        run_r(7'h01, 3'd4, OPC_OP_32, DIVW);
        run_r(7'h01, 3'd5, OPC_OP_32, DIVUW);
        run_r(7'h01, 3'd6, OPC_OP_32, REMW);
        run_r(7'h01, 3'd7, OPC_OP_32, REMUW);
    endtask

    task automatic test_imm_forms();
        run_i(3'd0, OPC_OP_IMM, ADDI, MEM_NONE, SIZE_BYTE);
        run_i(3'd2, OPC_OP_IMM, SLTI, MEM_NONE, SIZE_BYTE);
        run_i(3'd3, OPC_OP_IMM, SLTIU, MEM_NONE, SIZE_BYTE);
        run_i(3'd4, OPC_OP_IMM, XORI, MEM_NONE, SIZE_BYTE);
        run_i(3'd6, OPC_OP_IMM, ORI, MEM_NONE, SIZE_BYTE);
        run_i(3'd7, OPC_OP_IMM, ANDI, MEM_NONE, SIZE_BYTE);
        run_i(3'd0, OPC_OP_IMM_32, ADDIW, MEM_NONE, SIZE_BYTE);
        run_i(3'd0, OPC_JALR, JALR, MEM_NONE, SIZE_BYTE);
        run_shift(7'h00, 3'd1, OPC_OP_IMM, SLLI);
        run_shift(7'h00, 3'd5, OPC_OP_IMM, SRLI);
        run_shift(7'h20, 3'd5, OPC_OP_IMM, SRAI);
        run_shift(7'h00, 3'd1, OPC_OP_IMM_32, SLLIW);
        run_shift(7'h00, 3'd5, OPC_OP_IMM_32, SRLIW);
        run_shift(7'h20, 3'd5, OPC_OP_IMM_32, SRAIW);
        run_b(3'd0, BEQ);
        run_b(3'd1, BNE);
        run_b(3'd4, BLT);
        run_b(3'd5, BGE);
        run_b(3'd6, BLTU);
        run_b(3'd7, BGEU);
        run_u(OPC_LUI, LUI);
        run_u(OPC_AUIPC, AUIPC);
        run_j();
    endtask

    task automatic test_mem_ops();
        run_i(3'd0, OPC_LOAD, LB, MEM_READ, SIZE_BYTE);
        run_i(3'd1, OPC_LOAD, LH, MEM_READ, SIZE_HALF);
        run_i(3'd2, OPC_LOAD, LW, MEM_READ, SIZE_WORD);
        run_i(3'd3, OPC_LOAD, LD, MEM_READ, SIZE_DOUBLE);
        run_i(3'd4, OPC_LOAD, LBU, MEM_READ, SIZE_BYTE);
        run_i(3'd5, OPC_LOAD, LHU, MEM_READ, SIZE_HALF);
        run_i(3'd6, OPC_LOAD, LWU, MEM_READ, SIZE_WORD);
        run_s(3'd0, SB, SIZE_BYTE);
        run_s(3'd1, SH, SIZE_HALF);
        run_s(3'd2, SW, SIZE_WORD);
        run_s(3'd3, SD, SIZE_DOUBLE);
    endtask

    task automatic test_illegal();
        run_illegal(32'h0000_000f, "FENCE opcode");
        run_illegal(32'h0000_007f, "opcode 7f");
        run_illegal({7'h20, 10'h0, 3'd1, 5'd1, OPC_OP}, "OP alt funct7 with funct3 1");
        run_illegal({7'h01, 10'h0, 3'd1, 5'd1, OPC_OP_32}, "MULH in word form");
        run_illegal({12'h0, 5'd0, 3'd2, 5'd1, OPC_OP_IMM_32}, "OP_IMM_32 funct3 2");
        run_illegal({12'h0, 5'd0, 3'd7, 5'd1, OPC_LOAD}, "LOAD funct3 7");
        run_illegal({12'h0, 5'd0, 3'd4, 5'd1, OPC_STORE}, "STORE funct3 4");
        run_illegal({12'h0, 5'd0, 3'd2, 5'd1, OPC_BRANCH}, "BRANCH funct3 2");
        run_illegal({12'h0, 5'd0, 3'd1, 5'd1, OPC_JALR}, "JALR funct3 1");
        run_illegal(32'h0020_0073, "SYSTEM funct12 2");
        run_illegal(32'h3400_1073, "CSR write");
        send(32'h0000_0073);
        expect_result("ECALL", ECALL, OPC_SYSTEM, '0, '0, '0, 64'd0, '0,
                      MEM_NONE, SIZE_BYTE);
        send(32'h0010_0073);
        expect_result("EBREAK", EBREAK, OPC_SYSTEM, '0, '0, '0, 64'd1, '0,
                      MEM_NONE, SIZE_BYTE);
    endtask

    initial begin
        int total;
        reset = 1'b1;
        req   = 1'b0;
        instr = '0;
        void'($urandom(32'hd6a5));
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset();
        test_reg_ops();
        test_imm_forms();
        test_mem_ops();
        test_illegal();
        repeat (2) @(posedge clk);
        total = mismatch_count + protocol_count + dut_i.asserts_i.fail_count;
        $display("Errors: %0d mismatches, %0d protocol, %0d assertion",
                 mismatch_count, protocol_count, dut_i.asserts_i.fail_count);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_LIMIT);
        $display("Timeout: the tests did not finish within %0d ns", RUN_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/decode_stage_asserts.sv
// Decode stage handshake assertions
`default_nettype none

`include "rv_decode_defines.svh"

module decode_stage_asserts import rv_decode_pkg::*; (
    input logic                      clk,
    input logic                      reset,
    input logic                      req,
    input logic                      ack,
    input instr_e                    op,
    input logic [`RV_REG_ADDR_W-1:0] rd,
    input logic [`RV_REG_ADDR_W-1:0] rs1,
    input logic [`RV_REG_ADDR_W-1:0] rs2,
    input logic [`RV_XLEN-1:0]       imm,
    input logic [`RV_SHAMT_W-1:0]    shamt,
    input mem_access_e               mem_access,
    input access_size_e              access_size,
    input logic                      illegal
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // Read by the testbench summary

    ack_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin
            $error("ack high after a reset cycle");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            fail_count++;
        end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
            $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    // Results frozen for the whole ack phase
    results_stable: assert property (@(posedge clk) disable iff (reset)
            ack && $past(ack) |-> $stable({op, rd, rs1, rs2, imm, shamt,
                                           mem_access, access_size, illegal}))
        else begin
            $error("results changed while ack was high");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
// Registered RV64IM decode stage
`default_nettype none

`include "rv_decode_defines.svh"

module decode_stage import rv_decode_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  logic [`RV_ILEN-1:0]      instr,
    output logic                     ack,
    output instr_e                   op,
    output opcode_e                  opcode,
    output logic [`RV_REG_ADDR_W-1:0] rd,
    output logic [`RV_REG_ADDR_W-1:0] rs1,
    output logic [`RV_REG_ADDR_W-1:0] rs2,
    output logic [`RV_XLEN-1:0]      imm,
    output logic [`RV_SHAMT_W-1:0]   shamt,
    output access_size_e             access_size,
    output mem_access_e              mem_access,
    output logic                     illegal
);
    logic                      capture;
    logic                      load_result;
    logic [`RV_ILEN-1:0]       instr_q;

    instr_e                    cls_op;
    opcode_e                   cls_opcode;
    access_size_e              cls_access_size;
    mem_access_e               cls_mem_access;
    logic                      cls_illegal;
    logic [`RV_XLEN-1:0]       gen_imm;
    logic [`RV_SHAMT_W-1:0]    gen_shamt;
    logic [`RV_REG_ADDR_W-1:0] rd_d;
    logic [`RV_REG_ADDR_W-1:0] rs1_d;
    logic [`RV_REG_ADDR_W-1:0] rs2_d;

    decode_handshake handshake_i (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .ack         (ack),
        .capture     (capture),
        .load_result (load_result)
    );

    always_ff @(posedge clk) begin
        if (capture) instr_q <= instr;
    end

    op_classifier classifier_i (
        .instr       (instr_q),
        .op          (cls_op),
        .opcode      (cls_opcode),
        .access_size (cls_access_size),
        .mem_access  (cls_mem_access),
        .illegal     (cls_illegal)
    );

    imm_generator imm_gen_i (
        .instr  (instr_q),
        .opcode (cls_opcode),
        .imm    (gen_imm),
        .shamt  (gen_shamt)
    );

    // Fields a format does not carry read zero
    assign rd_d  = (cls_opcode == OPC_STORE || cls_opcode == OPC_BRANCH) ? '0 : instr_q[11:7];
    assign rs1_d = (cls_opcode == OPC_LUI || cls_opcode == OPC_AUIPC ||
                    cls_opcode == OPC_JAL || cls_opcode == OPC_SYSTEM) ? '0 : instr_q[19:15];
    assign rs2_d = (cls_opcode == OPC_OP || cls_opcode == OPC_OP_32 ||
                    cls_opcode == OPC_STORE || cls_opcode == OPC_BRANCH) ? instr_q[24:20] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            op          <= ILLEGAL; // Nothing decoded yet
            opcode      <= opcode_e'(7'b0);
            rd          <= '0;
            rs1         <= '0;
            rs2         <= '0;
            imm         <= '0;
            shamt       <= '0;
            access_size <= SIZE_BYTE;
            mem_access  <= MEM_NONE;
            illegal     <= 1'b1;
        end else if (load_result) begin
            op          <= cls_op;
            opcode      <= cls_opcode;
            rd          <= rd_d;
            rs1         <= rs1_d;
            rs2         <= rs2_d;
            imm         <= gen_imm;
            shamt       <= gen_shamt;
            access_size <= cls_access_size;
            mem_access  <= cls_mem_access;
            illegal     <= cls_illegal;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_handshake.sv
// Four-phase req/ack control
`default_nettype none

module decode_handshake import rv_decode_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic req,
    output logic ack,
    output logic capture,
    output logic load_result
);
    decode_state_e state;
    decode_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) state_next = DECODE;
            end
            DECODE: state_next = ACK; // Decode logic settles in one cycle
            ACK: begin
                // Hold results until upstream lets go
                if (!req) state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= (state_next == ACK);
        end
    end

    // Instruction latched on the edge that sees req
    assign capture = (state == IDLE) && req;

    // Results register one edge later
    assign load_result = (state == DECODE);

endmodule

`default_nettype wire

// File: decoder/imm_generator.sv
// Immediate and shift amount generator
`default_nettype none

`include "rv_decode_defines.svh"

module imm_generator import rv_decode_pkg::*; (
    input  logic [`RV_ILEN-1:0]    instr,
    input  opcode_e                opcode,
    output logic [`RV_XLEN-1:0]    imm,
    output logic [`RV_SHAMT_W-1:0] shamt
);
    logic                sign;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign sign = instr[31]; // Every format signs from bit 31

    assign imm_i = {{(`RV_XLEN-12){sign}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){sign}}, instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LOAD,
            OPC_OP_IMM,
            OPC_OP_IMM_32,
            OPC_JALR,
            OPC_SYSTEM: imm = imm_i;
            OPC_STORE:  imm = imm_s;
            OPC_BRANCH: imm = imm_b;
            OPC_LUI,
            OPC_AUIPC:  imm = imm_u;
            OPC_JAL:    imm = imm_j;
            default:    imm = '0; // R-type and unknown
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_OP_IMM:    shamt = instr[25:20];
            OPC_OP_IMM_32: shamt = {1'b0, instr[24:20]}; // Word shifts stop at 31
            default:       shamt = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: decoder/op_classifier.sv
// RV64IM operation classifier
`default_nettype none

`include "rv_decode_defines.svh"

module op_classifier import rv_decode_pkg::*; (
    input  logic [`RV_ILEN-1:0] instr,
    output instr_e              op,
    output opcode_e             opcode,
    output access_size_e        access_size,
    output mem_access_e         mem_access,
    output logic                illegal
);
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB and arithmetic shifts
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        op          = ILLEGAL;
        access_size = SIZE_BYTE;
        mem_access  = MEM_NONE;

        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    case (funct3)
                        3'b000: op = MUL;
                        3'b001: op = MULH;
                        3'b010: op = MULHSU;
                        3'b011: op = MULHU;
                        3'b100: op = DIV;
                        3'b101: op = DIVU;
                        3'b110: op = REM;
                        3'b111: op = REMU;
                    endcase
                end else if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000: op = ADD;
                        3'b001: op = SLL;
                        3'b010: op = SLT;
                        3'b011: op = SLTU;
                        3'b100: op = XOR;
                        3'b101: op = SRL;
                        3'b110: op = OR;
                        3'b111: op = AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000) op = SUB;
                    else if (funct3 == 3'b101) op = SRA;
                end
            end
            OPC_OP_32: begin
                if (funct7 == F7_MULDIV) begin
                    case (funct3)
                        3'b000: op = MULW;
                        3'b100: op = DIVW;
                        3'b101: op = DIVUW;
                        3'b110: op = REMW;
                        3'b111: op = REMUW;
                        default: op = ILLEGAL; // No MULH forms in W
                    endcase
                end else if (funct7 == F7_BASE) begin
                    if (funct3 == 3'b000) op = ADDW;
                    else if (funct3 == 3'b001) op = SLLW;
                    else if (funct3 == 3'b101) op = SRLW;
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000) op = SUBW;
                    else if (funct3 == 3'b101) op = SRAW;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = ADDI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                    3'b001: if (instr[31:26] == 6'b000000) op = SLLI;
                    3'b101: begin
                        // Six-bit shamt leaves only bits 31..26 as funct
                        if (instr[31:26] == 6'b000000) op = SRLI;
                        else if (instr[31:26] == 6'b010000) op = SRAI;
                    end
                endcase
            end
            OPC_OP_IMM_32: begin
                if (funct3 == 3'b000) op = ADDIW;
                else if (funct3 == 3'b001 && funct7 == F7_BASE) op = SLLIW;
                else if (funct3 == 3'b101 && funct7 == F7_BASE) op = SRLIW;
                else if (funct3 == 3'b101 && funct7 == F7_ALT) op = SRAIW;
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000: op = LB;
                    3'b001: op = LH;
                    3'b010: op = LW;
                    3'b011: op = LD;
                    3'b100: op = LBU;
                    3'b101: op = LHU;
                    3'b110: op = LWU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000: op = SB;
                    3'b001: op = SH;
                    3'b010: op = SW;
                    3'b011: op = SD;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000: op = BEQ;
                    3'b001: op = BNE;
                    3'b100: op = BLT;
                    3'b101: op = BGE;
                    3'b110: op = BLTU;
                    3'b111: op = BGEU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_JAL:   op = JAL;
            OPC_JALR:  if (funct3 == 3'b000) op = JALR;
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_SYSTEM: begin
                if (funct3 == 3'b000 && instr[31:20] == 12'h000) op = ECALL;
                else if (funct3 == 3'b000 && instr[31:20] == 12'h001) op = EBREAK;
            end
            default: op = ILLEGAL;
        endcase

        // Size and kind only for a legal memory op
        if (op != ILLEGAL && (opcode == OPC_LOAD || opcode == OPC_STORE)) begin
            access_size = access_size_e'(funct3[1:0]);
            mem_access  = (opcode == OPC_LOAD) ? MEM_READ : MEM_WRITE;
        end
    end

    assign illegal = (op == ILLEGAL);

endmodule

`default_nettype wire

// File: common/rv_decode_pkg.sv
// RV64IM decode types
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

    // Major opcodes handled by the stage
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    // Decoded operation, 27 and 28 unused
    typedef enum logic [7:0] {
        ADD    = 8'd0,  SUB    = 8'd1,  XOR    = 8'd2,  OR     = 8'd3,
        AND    = 8'd4,  SLL    = 8'd5,  SRL    = 8'd6,  SRA    = 8'd7,
        SLT    = 8'd8,  SLTU   = 8'd9,  MUL    = 8'd10, MULH   = 8'd11,
        MULHSU = 8'd12, MULHU  = 8'd13, DIV    = 8'd14, DIVU   = 8'd15,
        REM    = 8'd16, REMU   = 8'd17, ADDI   = 8'd18, XORI   = 8'd19,
        ORI    = 8'd20, ANDI   = 8'd21, SLLI   = 8'd22, SRLI   = 8'd23,
        SRAI   = 8'd24, SLTI   = 8'd25, SLTIU  = 8'd26, ADDIW  = 8'd29,
        SLLIW  = 8'd30, SRLIW  = 8'd31, SRAIW  = 8'd32, ADDW   = 8'd33,
        SUBW   = 8'd34, SLLW   = 8'd35, SRLW   = 8'd36, SRAW   = 8'd37,
        MULW   = 8'd38, DIVW   = 8'd39, DIVUW  = 8'd40, REMW   = 8'd41,
        REMUW  = 8'd42, SB     = 8'd43, SH     = 8'd44, SW     = 8'd45,
        SD     = 8'd46, BEQ    = 8'd47, BNE    = 8'd48, BLT    = 8'd49,
        BGE    = 8'd50, BLTU   = 8'd51, BGEU   = 8'd52, JAL    = 8'd53,
        JALR   = 8'd54, LUI    = 8'd55, AUIPC  = 8'd56, ECALL  = 8'd57,
        EBREAK = 8'd58, LB     = 8'd59, LH     = 8'd60, LW     = 8'd61,
        LBU    = 8'd62, LHU    = 8'd63, LWU    = 8'd64, LD     = 8'd65,
        ILLEGAL = 8'd255
    } instr_e;

    // Memory access width, same code as funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } access_size_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_access_e;

    // Four-phase handshake
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        DECODE = 2'd1,
        ACK    = 2'd2
    } decode_state_e;

endpackage

`default_nettype wire

// File: common/rv_decode_defines.svh
// RV64IM decode widths
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Data path width
`define RV_XLEN 64

// Instruction word, base ISA only
`define RV_ILEN 32

// Register file index
`define RV_REG_ADDR_W 5

// Shift amount, wide enough for RV64 shifts
`define RV_SHAMT_W 6

`endif
